//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decoder_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
rtl/mmix_decode_pkg.sv
rtl/opcode_table.sv
rtl/operand_decoder.sv
rtl/reg_stack_counters.sv
rtl/dispatch_fsm.sv
rtl/mmix_decoder_top.sv
tests/decoder_checker.sv
tests/decoder_tb.sv

//--- rtl/dispatch_fsm.sv
// dispatch FSM
// latches one instruction, inserts incrl / incgamma stack commands while X
// is marginal, then emits the instruction itself, one word per cycle
`timescale 1ns/1ns

module dispatch_fsm (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          inst_valid,
	input  mmix_decode_pkg::inst_t        inst,
	input  logic [63:0]                   loc,
	input  mmix_decode_pkg::internal_op_e iop,
	input  logic                          supported,
	input  mmix_decode_pkg::dest_t        x,
	input  mmix_decode_pkg::spec_t        y,
	input  mmix_decode_pkg::spec_t        z,
	input  mmix_decode_pkg::spec_t        b,
	input  logic                          x_marginal,
	input  logic                          ring_full,
	input  logic [7:0]                    l,
	input  logic [7:0]                    o,
	input  logic [7:0]                    s,
	output mmix_decode_pkg::inst_t        cur_inst,
	output logic [63:0]                   cur_loc,
	output logic                          inc_l,
	output logic                          inc_s,
	output logic                          busy,
	output logic                          disp_valid,
	output mmix_decode_pkg::dispatch_t    disp
);
	import mmix_decode_pkg::*;

	typedef enum logic {
		idle,
		issue
	} state_e;

	state_e state;
	state_e state_nx;
	logic   stack_ins;
	logic   ins_gamma;
	logic   ins_rl;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= state_nx;
	end

	// instruction and location held for the whole issue run
	always_ff @(posedge clk) begin
		if (inst_valid && state == idle) begin
			cur_inst <= inst;
			cur_loc <= loc;
		end
	end

	// insertion needed this cycle, spill first when the ring is full
	assign stack_ins = (state == issue) && supported && x_marginal;
	assign ins_gamma = stack_ins && ring_full;
	assign ins_rl = stack_ins && !ring_full;
	assign inc_s = ins_gamma;
	assign inc_l = ins_rl;

	assign busy = (state == issue);
	assign disp_valid = (state == issue);

	always_comb begin
		state_nx = state;
		case (state)
			idle: if (inst_valid) state_nx = issue;
			// stay until the counters have caught up with X
			issue: if (!stack_ins) state_nx = idle;
			default: state_nx = idle;
		endcase
	end

	always_comb begin
		disp = '0;
		if (ins_gamma) begin
			// store ring slot S at address 8*S
			disp.op = incgamma;
			disp.opcode = op_stou;
			disp.y.value = {53'd0, s, 3'b000};
			disp.b.kind = spec_local;
			disp.b.addr = s & LRING_MASK;
			disp.interim = 1'b1;
			disp.spill = 1'b1;
		end else if (ins_rl) begin
			// clear the next ring slot, handled like a SETH
			disp.op = incrl;
			disp.opcode = op_seth;
			disp.x.valid = 1'b1;
			disp.x.kind = spec_local;
			disp.x.addr = (o + l) & LRING_MASK;
			disp.interim = 1'b1;
		end else begin
			disp.op = iop;
			disp.opcode = cur_inst.op;
			// trap words go out bare
			if (supported) begin
				disp.x = x;
				disp.y = y;
				disp.z = z;
				disp.b = b;
			end
		end
	end

	// source waits for busy low before strobing
	a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(inst_valid && busy));

endmodule

//--- rtl/mmix_decode_pkg.sv
// mmix decode package
// ring geometry, flag bit positions, opcode and internal-op encodings,
// and the operand and dispatch word layouts shared by the decoder blocks
package mmix_decode_pkg;

	// local register ring, kept small so spills show up early
	localparam int LRING_SIZE = 16;
	localparam logic [7:0] LRING_MASK = 8'(LRING_SIZE - 1);

	// bit positions in the per-opcode flags byte
	localparam int FLAG_Z_IMM    = 0;	// Z is an immediate
	localparam int FLAG_Z_REG    = 1;	// rZ is a source
	localparam int FLAG_Y_IMM    = 2;	// Y is an immediate
	localparam int FLAG_Y_REG    = 3;	// rY is a source
	localparam int FLAG_X_SRC    = 4;	// rX is a source
	localparam int FLAG_X_DEST   = 5;	// rX is the destination
	localparam int FLAG_REL_ADDR = 6;	// YZ or XYZ is a relative address

	// opcodes that the decoder compares against by value
	typedef enum logic [7:0] {
		op_stou = 8'hae,
		op_seth = 8'he0,
		op_jmp  = 8'hf0,
		op_geta = 8'hf4
	} mmix_opcode_e;

	// internal ops handed to the execution units
	typedef enum logic [4:0] {
		trap_op,
		add,
		addu,
		sub,
		subu,
		cmp,
		cmpu,
		shl,
		shlu,
		shr,
		shru,
		br,
		pbr,
		cset,
		zset,
		ld,
		st,
		or_op,
		orn,
		nor_op,
		xor_op,
		and_op,
		andn,
		nand_op,
		nxor,
		set,
		jmp,
		incrl,		// inserted, advances L
		incgamma	// inserted, spills ring slot S
	} internal_op_e;

	// where an operand comes from
	typedef enum logic [1:0] {
		spec_imm    = 2'd0,
		spec_global = 2'd1,
		spec_local  = 2'd2
	} spec_kind_e;

	// source operand, value only meaningful for immediates
	typedef struct packed {
		logic [63:0] value;
		spec_kind_e  kind;
		logic [7:0]  addr;	// global number or ring slot
	} spec_t;

	// destination register
	typedef struct packed {
		logic       valid;
		spec_kind_e kind;
		logic [7:0] addr;
	} dest_t;

	// one dispatched command word
	typedef struct packed {
		internal_op_e op;
		logic [7:0]   opcode;
		dest_t        x;
		spec_t        y;
		spec_t        z;
		spec_t        b;
		logic         interim;	// inserted stack command
		logic         spill;	// incgamma store of a ring slot
	} dispatch_t;

	// raw instruction word, OP X Y Z
	typedef struct packed {
		logic [7:0] op;
		logic [7:0] xx;
		logic [7:0] yy;
		logic [7:0] zz;
	} inst_t;

endpackage

//--- rtl/mmix_decoder_top.sv
// mmix decoder top
// connects the opcode table, operand decoder, stack counters and dispatch FSM
`timescale 1ns/1ns

module mmix_decoder_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       inst_valid,
	input  mmix_decode_pkg::inst_t     inst,
	input  logic [63:0]                loc,
	input  logic [7:0]                 g,
	output logic                       busy,
	output logic                       disp_valid,
	output mmix_decode_pkg::dispatch_t disp
);
	import mmix_decode_pkg::*;

	inst_t        cur_inst;
	logic [63:0]  cur_loc;
	internal_op_e iop;
	logic [7:0]   flags;
	logic         supported;
	dest_t        x;
	spec_t        y;
	spec_t        z;
	spec_t        b;
	logic         x_marginal;
	logic         ring_full;
	logic [7:0]   l;
	logic [7:0]   o;
	logic [7:0]   s;
	logic         inc_l;
	logic         inc_s;

	opcode_table u_table (
		.op(cur_inst.op), .iop(iop), .flags(flags), .supported(supported)
	);

	operand_decoder u_operands (
		.inst(cur_inst), .loc(cur_loc), .iop(iop), .flags(flags),
		.g(g), .l(l), .o(o), .s(s),
		.x(x), .y(y), .z(z), .b(b),
		.x_marginal(x_marginal), .ring_full(ring_full)
	);

	reg_stack_counters u_counters (
		.clk(clk), .rst_n(rst_n), .inc_l(inc_l), .inc_s(inc_s),
		.l(l), .o(o), .s(s)
	);

	dispatch_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst), .loc(loc),
		.iop(iop), .supported(supported), .x(x), .y(y), .z(z), .b(b),
		.x_marginal(x_marginal), .ring_full(ring_full), .l(l), .o(o), .s(s),
		.cur_inst(cur_inst), .cur_loc(cur_loc), .inc_l(inc_l), .inc_s(inc_s),
		.busy(busy), .disp_valid(disp_valid), .disp(disp)
	);

endmodule

//--- rtl/opcode_table.sv
// opcode table
// classifies an 8-bit MMIX opcode into an internal op, its operand flags
// and a supported bit; unsupported opcodes fall back to trap_op
`timescale 1ns/1ns

module opcode_table (
	input  logic [7:0]                    op,
	output mmix_decode_pkg::internal_op_e iop,
	output logic [7:0]                    flags,
	output logic                          supported
);
	import mmix_decode_pkg::*;

	logic [7:0] z_sel;
	logic [7:0] f_arith;

	// odd opcodes take an immediate Z, even ones a register
	assign z_sel = op[0] ? (8'd1 << FLAG_Z_IMM) : (8'd1 << FLAG_Z_REG);
	// usual three-register form, X dest with Y and Z sources
	assign f_arith = (8'd1 << FLAG_X_DEST) | (8'd1 << FLAG_Y_REG) | z_sel;

	always_comb begin
		iop = trap_op;
		flags = 8'd0;
		supported = 1'b1;
		// one arm per group of eight opcodes
		case (op[7:3])
			5'h04: begin
				// ADD ADDU SUB SUBU
				case (op[2:1])
					2'd0: iop = add;
					2'd1: iop = addu;
					2'd2: iop = sub;
					default: iop = subu;
				endcase
				flags = f_arith;
			end
			5'h05: begin
				// scaled 2ADDU .. 16ADDU
				iop = addu;
				flags = f_arith;
			end
			5'h06: begin
				case (op[2:1])
					2'd0: iop = cmp;
					2'd1: iop = cmpu;
					2'd2: iop = sub;
					default: iop = subu;
				endcase
				// NEG has an unsigned constant in Y
				if (op[2])
					flags = (8'd1 << FLAG_X_DEST) | (8'd1 << FLAG_Y_IMM) | z_sel;
				else
					flags = f_arith;
			end
			5'h07: begin
				case (op[2:1])
					2'd0: iop = shl;
					2'd1: iop = shlu;
					2'd2: iop = shr;
					default: iop = shru;
				endcase
				flags = f_arith;
			end
			5'h08, 5'h09: begin
				iop = br;
				flags = (8'd1 << FLAG_REL_ADDR) | (8'd1 << FLAG_X_SRC);
			end
			5'h0a, 5'h0b: begin
				iop = pbr;
				flags = (8'd1 << FLAG_REL_ADDR) | (8'd1 << FLAG_X_SRC);
			end
			5'h0c, 5'h0d: begin
				// CS keeps old X when the test fails
				iop = cset;
				flags = f_arith | (8'd1 << FLAG_X_SRC);
			end
			5'h0e, 5'h0f: begin
				iop = zset;
				flags = f_arith;
			end
			5'h10, 5'h11: begin
				iop = ld;
				flags = f_arith;
			end
			5'h14, 5'h15: begin
				// stores read X, write nothing
				iop = st;
				flags = (8'd1 << FLAG_X_SRC) | (8'd1 << FLAG_Y_REG) | z_sel;
			end
			5'h18: begin
				case (op[2:1])
					2'd0: iop = or_op;
					2'd1: iop = orn;
					2'd2: iop = nor_op;
					default: iop = xor_op;
				endcase
				flags = f_arith;
			end
			5'h19: begin
				case (op[2:1])
					2'd0: iop = and_op;
					2'd1: iop = andn;
					2'd2: iop = nand_op;
					default: iop = nxor;
				endcase
				flags = f_arith;
			end
			5'h1c: begin
				// SETH..SETL, then INCH..INCL as an add of X
				iop = op[2] ? addu : set;
				flags = (8'd1 << FLAG_X_DEST) | (op[2] ? (8'd1 << FLAG_X_SRC) : 8'd0);
			end
			5'h1d: begin
				// ORH..ORL, ANDNH..ANDNL
				iop = op[2] ? andn : or_op;
				flags = (8'd1 << FLAG_X_DEST) | (8'd1 << FLAG_X_SRC);
			end
			5'h1e: begin
				case (op[2:1])
					2'd0: begin
						iop = jmp;
						flags = 8'd1 << FLAG_REL_ADDR;
					end
					2'd2: begin
						// GETA puts the target address in X
						iop = set;
						flags = (8'd1 << FLAG_REL_ADDR) | (8'd1 << FLAG_X_DEST);
					end
					default: supported = 1'b0;	// PUSHJ, PUT
				endcase
			end
			default: supported = 1'b0;
		endcase
	end

endmodule

//--- rtl/operand_decoder.sv
// operand decoder
// turns the instruction fields into X, Y, Z and B operand specs using the
// register-stack counters, and judges whether X is marginal and the ring full
`timescale 1ns/1ns

module operand_decoder (
	input  mmix_decode_pkg::inst_t        inst,
	input  logic [63:0]                   loc,
	input  mmix_decode_pkg::internal_op_e iop,
	input  logic [7:0]                    flags,
	input  logic [7:0]                    g,
	input  logic [7:0]                    l,
	input  logic [7:0]                    o,
	input  logic [7:0]                    s,
	output mmix_decode_pkg::dest_t        x,
	output mmix_decode_pkg::spec_t        y,
	output mmix_decode_pkg::spec_t        z,
	output mmix_decode_pkg::spec_t        b,
	output logic                          x_marginal,
	output logic                          ring_full
);
	import mmix_decode_pkg::*;

	// register number to spec, global at or above G, else a ring slot
	function automatic spec_t map_reg(input logic [7:0] r, input logic [7:0] gg,
		input logic [7:0] oo);
		spec_t sp;
		sp.value = 64'd0;
		if (r >= gg) begin
			sp.kind = spec_global;
			sp.addr = r;
		end else begin
			sp.kind = spec_local;
			sp.addr = (oo + r) & LRING_MASK;
		end
		return sp;
	endfunction

	logic [15:0] yz;
	logic        is_wyde;
	logic        is_jmp;
	logic [63:0] rel_off;
	spec_t       x_map;

	assign yz = {inst.yy, inst.zz};
	assign is_wyde = (inst.op[7:4] == 4'he);
	assign is_jmp = ((inst.op & 8'hfe) == op_jmp);
	// backward forms have the opcode low bit set, so it acts as the sign
	assign rel_off = is_jmp ? {{38{inst.op[0]}}, inst.xx, yz, 2'b00}
	                        : {{46{inst.op[0]}}, yz, 2'b00};
	assign x_map = map_reg(inst.xx, g, o);

	// X in [L, G) has no ring slot yet
	assign x_marginal = flags[FLAG_X_DEST] && (inst.xx >= l) && (inst.xx < g);
	// no free slot between beta and gamma
	assign ring_full = ((8'(s - o - l - 8'd1) & LRING_MASK) == 8'd0);

	always_comb begin
		x = '0;
		if (flags[FLAG_X_DEST] && !x_marginal) begin
			x.valid = 1'b1;
			x.kind = x_map.kind;
			x.addr = x_map.addr;
		end
	end

	always_comb begin
		y = '0;
		z = '0;
		b = '0;
		if (flags[FLAG_REL_ADDR]) begin
			// y carries the return point, z the target
			y.value = loc + 64'd4;
			z.value = loc + rel_off;
		end else if (is_wyde) begin
			// place the wyde by the low opcode bits, H MH ML L
			case (inst.op[1:0])
				2'd0: z.value = {yz, 48'd0};
				2'd1: z.value = {16'd0, yz, 32'd0};
				2'd2: z.value = {32'd0, yz, 16'd0};
				default: z.value = {48'd0, yz};
			endcase
			// INC OR ANDN combine with the old X
			if (iop != set)
				y = x_map;
		end else begin
			if (flags[FLAG_Z_IMM])
				z.value = {56'd0, inst.zz};
			else if (flags[FLAG_Z_REG])
				z = map_reg(inst.zz, g, o);
			if (flags[FLAG_Y_IMM])
				y.value = {56'd0, inst.yy};
			else if (flags[FLAG_Y_REG])
				y = map_reg(inst.yy, g, o);
		end
		// stores, branches and CS read X through b
		if (flags[FLAG_X_SRC] && !is_wyde)
			b = x_map;
	end

endmodule

//--- rtl/reg_stack_counters.sv
// register-stack counters
// holds L, O and S; L and S step by one when the dispatch FSM inserts
// an incrl or an incgamma command
`timescale 1ns/1ns

module reg_stack_counters (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       inc_l,
	input  logic       inc_s,
	output logic [7:0] l,
	output logic [7:0] o,
	output logic [7:0] s
);
	import mmix_decode_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			l <= 8'd0;
			s <= 8'd0;
		end else begin
			// new local made live
			if (inc_l)
				l <= l + 8'd1;
			// oldest ring slot spilled
			if (inc_s)
				s <= s + 8'd1;
		end
	end

	// no push or pop here, so the frame base never moves
	assign o = 8'd0;

	// the FSM emits one command per cycle
	a_one_step: assert property (@(posedge clk) disable iff (!rst_n)
		!(inc_l && inc_s));

	// live locals between gamma and beta must fit in the ring; this relies on
	// the decoder spilling before L grows into a full ring
	a_ring_fits: assert property (@(posedge clk) disable iff (!rst_n)
		8'(l + o - s) <= LRING_MASK);

endmodule

//--- tests/decoder_checker.sv
// dispatch checker
// keeps its own register-stack state, expands each accepted instruction
// into the expected dispatch words and compares them with the DUT in order
`timescale 1ns/1ns

module decoder_checker (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       inst_valid,
	input  mmix_decode_pkg::inst_t     inst,
	input  logic [63:0]                loc,
	input  logic [7:0]                 g,
	input  logic                       busy,
	input  logic                       disp_valid,
	input  mmix_decode_pkg::dispatch_t disp,
	output int                         errors,
	output int                         words
);
	import mmix_decode_pkg::*;

	dispatch_t  exp_q[$];
	logic [7:0] ref_l;
	logic [7:0] ref_s;
	int         err_cnt = 0;
	int         word_cnt = 0;

	assign errors = err_cnt;
	assign words = word_cnt;

	// immediate operand
	function automatic spec_t imm_spec(input logic [63:0] v);
		spec_t sp;
		sp = '0;
		sp.value = v;
		return sp;
	endfunction

	// register operand with O at zero, so the ring slot is r mod 16
	function automatic spec_t reg_spec(input logic [7:0] r, input logic [7:0] gg);
		spec_t sp;
		sp = '0;
		if (r < gg) begin
			sp.kind = spec_local;
			sp.addr = {4'd0, r[3:0]};
		end else begin
			sp.kind = spec_global;
			sp.addr = r;
		end
		return sp;
	endfunction

	function automatic internal_op_e pick4(input logic [1:0] sel, input internal_op_e a0,
		input internal_op_e a1, input internal_op_e a2, input internal_op_e a3);
		case (sel)
			2'd0: return a0;
			2'd1: return a1;
			2'd2: return a2;
			default: return a3;
		endcase
	endfunction

	// reference model that queues the inserted stack words and then the instruction
	function automatic void expand_inst(input inst_t i, input logic [63:0] pc,
		input logic [7:0] gg);
		dispatch_t    w;
		internal_op_e op;
		logic [15:0]  yz;
		logic [63:0]  off;
		logic         ok;
		logic         dest;
		logic         xsrc;
		logic         rel;
		logic         wyde;
		logic         yimm;
		int           sh;
		yz = {i.yy, i.zz};
		op = trap_op;
		ok = 1'b1;
		dest = 1'b0;
		xsrc = 1'b0;
		rel = 1'b0;
		wyde = 1'b0;
		yimm = 1'b0;
		case (i.op[7:4])
			4'h2: begin
				// upper half is the scaled ADDU family
				op = i.op[3] ? addu : pick4(i.op[2:1], add, addu, sub, subu);
				dest = 1'b1;
			end
			4'h3: begin
				if (i.op[3])
					op = pick4(i.op[2:1], shl, shlu, shr, shru);
				else
					op = pick4(i.op[2:1], cmp, cmpu, sub, subu);
				// NEG and NEGU take Y as a constant
				yimm = !i.op[3] && i.op[2];
				dest = 1'b1;
			end
			4'h4, 4'h5: begin
				op = i.op[4] ? pbr : br;
				rel = 1'b1;
				xsrc = 1'b1;
			end
			4'h6: begin
				op = cset;
				dest = 1'b1;
				xsrc = 1'b1;
			end
			4'h7: begin
				op = zset;
				dest = 1'b1;
			end
			4'h8: begin
				op = ld;
				dest = 1'b1;
			end
			4'ha: begin
				op = st;
				xsrc = 1'b1;
			end
			4'hc: begin
				if (i.op[3])
					op = pick4(i.op[2:1], and_op, andn, nand_op, nxor);
				else
					op = pick4(i.op[2:1], or_op, orn, nor_op, xor_op);
				dest = 1'b1;
			end
			4'he: begin
				// SET INC OR ANDN, four wyde positions each
				op = pick4(i.op[3:2], set, addu, or_op, andn);
				dest = 1'b1;
				wyde = 1'b1;
			end
			4'hf: begin
				if (i.op[3:1] == 3'd0) begin
					op = jmp;
					rel = 1'b1;
				end else if (i.op[3:1] == 3'd2) begin
					op = set;
					rel = 1'b1;
					dest = 1'b1;
				end else begin
					ok = 1'b0;
				end
			end
			default: ok = 1'b0;
		endcase

		// X in [L, G) needs ring slots first
		while (dest && i.xx >= ref_l && i.xx < gg) begin
			w = '0;
			w.interim = 1'b1;
			if (8'(ref_l - ref_s) == 8'(LRING_SIZE - 1)) begin
				// 15 live locals so the oldest slot spills
				w.op = incgamma;
				w.opcode = 8'hae;
				w.y = imm_spec({53'd0, ref_s, 3'd0});
				w.b.kind = spec_local;
				w.b.addr = {4'd0, ref_s[3:0]};
				w.spill = 1'b1;
				ref_s = ref_s + 8'd1;
			end else begin
				w.op = incrl;
				w.opcode = 8'he0;
				w.x.valid = 1'b1;
				w.x.kind = spec_local;
				w.x.addr = {4'd0, ref_l[3:0]};
				ref_l = ref_l + 8'd1;
			end
			exp_q.push_back(w);
		end

		w = '0;
		w.op = op;
		w.opcode = i.op;
		if (ok) begin
			if (dest) begin
				w.x.valid = 1'b1;
				w.x.kind = reg_spec(i.xx, gg).kind;
				w.x.addr = reg_spec(i.xx, gg).addr;
			end
			if (rel) begin
				// backward forms have the odd opcode and only JMP takes XYZ
				if (i.op[7:1] == 7'h78) begin
					off = {40'd0, i.xx, yz};
					if (i.op[0])
						off = off - 64'h0000_0000_0100_0000;
				end else begin
					off = {48'd0, yz};
					if (i.op[0])
						off = off - 64'h0000_0000_0001_0000;
				end
				w.y = imm_spec(pc + 64'd4);
				w.z = imm_spec(pc + (off << 2));
			end else if (wyde) begin
				sh = 48 - 16 * int'(i.op[1:0]);
				w.z = imm_spec({48'd0, yz} << sh);
				if (op != set)
					w.y = reg_spec(i.xx, gg);
			end else begin
				w.z = i.op[0] ? imm_spec({56'd0, i.zz}) : reg_spec(i.zz, gg);
				w.y = yimm ? imm_spec({56'd0, i.yy}) : reg_spec(i.yy, gg);
			end
			if (xsrc)
				w.b = reg_spec(i.xx, gg);
		end
		exp_q.push_back(w);
	endfunction

	task automatic check_field(input string name, input logic [79:0] e,
		input logic [79:0] a);
		if (e !== a) begin
			$display("ERR %0t %s exp %h got %h", $time, name, e, a);
			err_cnt++;
		end
	endtask

	task automatic compare_word(input dispatch_t e);
		check_field("disp.op", 80'(e.op), 80'(disp.op));
		check_field("disp.opcode", 80'(e.opcode), 80'(disp.opcode));
		check_field("disp.x", 80'(e.x), 80'(disp.x));
		check_field("disp.y", 80'(e.y), 80'(disp.y));
		check_field("disp.z", 80'(e.z), 80'(disp.z));
		check_field("disp.b", 80'(e.b), 80'(disp.b));
		check_field("disp.interim", 80'(e.interim), 80'(disp.interim));
		check_field("disp.spill", 80'(e.spill), 80'(disp.spill));
	endtask

	// sample mid-cycle once the DUT has settled
	always @(negedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			ref_l = 8'd0;
			ref_s = 8'd0;
			if (busy || disp_valid) begin
				$display("busy or dispatch strobe high during reset at %0t", $time);
				err_cnt++;
			end
		end else begin
			// busy exactly while words are owed
			if (busy !== 1'(exp_q.size() != 0)) begin
				$display("ERR %0t busy exp %b got %b", $time, exp_q.size() != 0, busy);
				err_cnt++;
			end
			if (disp_valid) begin
				if (exp_q.size() == 0) begin
					$display("unexpected dispatch strobe at %0t", $time);
					err_cnt++;
				end else begin
					compare_word(exp_q.pop_front());
					word_cnt++;
				end
			end else if (exp_q.size() != 0) begin
				$display("dispatch missing at %0t, %0d expected words not seen",
					$time, exp_q.size());
				err_cnt++;
				exp_q.delete();
			end
			// new instruction starts dispatching next cycle
			if (inst_valid)
				expand_inst(inst, loc, g);
		end
	end

endmodule

//--- tests/decoder_tb.sv
// decoder testbench
// clock, reset and instruction stimulus for the MMIX dispatch decoder,
// with a watchdog; the checker module does the comparing
`timescale 1ns/1ns

module decoder_tb;
	import mmix_decode_pkg::*;

	localparam int CLK_NS  = 10;
	localparam int N_ARITH = 20;
	localparam int N_BAD   = 11;
	// stack growth, arith list, spill run, branches, wyde group, trap list
	localparam int N_FIXED = 1 + N_ARITH + 2 + 9 + 16 + N_BAD;
	localparam int N_RAND  = 60;
	localparam int N_INST  = N_FIXED + N_RAND;

	// arithmetic, logic, CS, load and store forms
	localparam logic [7:0] ARITH_OPS [N_ARITH] = '{
		8'h20, 8'h21, 8'h23, 8'h26, 8'h2b, 8'h30, 8'h33, 8'h35, 8'h39, 8'h3e,
		8'hc0, 8'hc5, 8'hc7, 8'hc8, 8'hcb, 8'hcd, 8'hce, 8'h60, 8'h8e, 8'had
	};
	// TRAP, MUL, DIVUI, LDSF, PRELD, STSF, MUX, PUSHJ, PUT, POP, TRIP
	localparam logic [7:0] BAD_OPS [N_BAD] = '{
		8'h00, 8'h18, 8'h1f, 8'h90, 8'h9c, 8'hb0, 8'hd8, 8'hf2, 8'hf6, 8'hf8, 8'hff
	};

	logic        clk;
	logic        rst_n;
	logic        inst_valid;
	inst_t       inst;
	logic [63:0] loc;
	logic [7:0]  g;
	logic        busy;
	logic        disp_valid;
	dispatch_t   disp;
	int          errors;
	int          words;
	int          sent;
	int          seed;

	mmix_decoder_top DUT (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst), .loc(loc),
		.g(g), .busy(busy), .disp_valid(disp_valid), .disp(disp)
	);

	decoder_checker u_checker (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst), .loc(loc),
		.g(g), .busy(busy), .disp_valid(disp_valid), .disp(disp),
		.errors(errors), .words(words)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	// one-cycle strobe once the decoder is free
	task automatic send_inst(input logic [7:0] op, input logic [7:0] xx,
		input logic [7:0] yy, input logic [7:0] zz, input logic [63:0] pc);
		while (busy) begin
			@(posedge clk);
			#1;
		end
		inst_valid = 1'b1;
		inst = {op, xx, yy, zz};
		loc = pc;
		@(posedge clk);
		#1;
		inst_valid = 1'b0;
		sent++;
	endtask

	// about 40 cycles per instruction on average
	initial begin
		#((N_INST * 40 + 10) * CLK_NS);
		$display("timeout, dispatch still running after %0d instructions", sent);
		$display("Test failures found");
		$finish;
	end

	initial begin
		inst_valid = 1'b0;
		inst = '0;
		loc = 64'd0;
		g = 8'd32;
		rst_n = 1'b0;
		seed = 55908;
		sent = 0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// X above L gives four incrl, then L = 4
		send_inst(8'h20, 8'd3, 8'd40, 8'd1, 64'h100);
		// X now below L or global
		for (int k = 0; k < N_ARITH; k++)
			send_inst(ARITH_OPS[k], k[0] ? 8'(k % 4) : 8'(32 + k), rand_byte(),
				rand_byte(), 64'h200 + 64'(k * 4));

		// L grows past 15, spills interleave
		send_inst(8'he3, 8'd20, 8'h12, 8'h34, 64'h4000);
		send_inst(8'h8f, 8'd25, 8'd34, 8'd8, 64'h4004);

		// branches, JMP and GETA, both directions
		send_inst(8'h42, 8'd2, 8'h00, 8'h10, 64'h1000);
		send_inst(8'h45, 8'd40, 8'hff, 8'hf0, 64'h2000);
		send_inst(8'h4e, 8'd1, 8'h80, 8'h00, 64'h3000);
		send_inst(8'h53, 8'd3, 8'h00, 8'h01, 64'h40);
		send_inst(8'h5c, 8'd33, 8'h12, 8'h34, 64'h0000_0001_0000_0000);
		send_inst(8'hf0, 8'h00, 8'h01, 8'h00, 64'h0000_0001_0000_0100);
		send_inst(8'hf1, 8'hff, 8'hff, 8'hfe, 64'h0000_0001_0000_0100);
		send_inst(8'hf4, 8'd5, 8'h00, 8'h20, 64'h6000);
		send_inst(8'hf5, 8'd40, 8'hff, 8'h00, 64'h6004);

		// SET, INC, OR, ANDN at every wyde position
		for (int k = 0; k < 16; k++)
			send_inst(8'he0 + 8'(k), 8'(k % 8), rand_byte(), rand_byte(),
				64'h5000 + 64'(k * 4));

		for (int k = 0; k < N_BAD; k++)
			send_inst(BAD_OPS[k], rand_byte(), rand_byte(), rand_byte(), 64'h7000);

		// random mix, X sometimes marginal
		for (int k = 0; k < N_RAND; k++)
			send_inst(rand_byte(), rand_byte() % 8'd40, rand_byte(), rand_byte(),
				{32'($random(seed)), 32'($random(seed)) & 32'hffff_fffc});

		while (busy) begin
			@(posedge clk);
			#1;
		end
		repeat (3) @(posedge clk);
		$display("checked %0d instructions, %0d dispatch words, %0d errors",
			sent, words, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
